// File: include/line_code_config.svh
`ifndef LINE_CODE_CONFIG_SVH
`define LINE_CODE_CONFIG_SVH

// word address width of the wishbone slave, three registers fit in two bits
`define LC_ADDR_W 2

// register word offsets
`define LC_REG_TX     2'd0
`define LC_REG_RX     2'd1
`define LC_REG_STATUS 2'd2

// upper bound in clocks on any wait for ack or for received data
`define LC_TIMEOUT 200

`endif

// File: design/line_code_types_pkg.sv
package line_code_types_pkg;

	// the two sub-blocks of one symbol, first transmitted bit on the left
	// six holds a,b,c,d,e,i and four holds f,g,h,j
	typedef struct packed {
		logic [5:0] six;
		logic [3:0] four;
	} code_blocks_t;

	// one 10-bit line symbol
	// the encoder builds it as a whole word, the decoder mostly looks at
	// the two sub-blocks separately, and the run check spans the boundary
	typedef union packed {
		logic [9:0]   word;
		code_blocks_t blk;
	} code_word_t;

	// idle character K28.5, K flag in bit 8 and byte 8'hBC below it
	// the encoder sends it whenever nothing is pending, the decoder
	// suppresses it from the receive strobe
	localparam logic [8:0] LC_IDLE_COMMA = {1'b1, 8'hBC};

endpackage

// File: design/line_code_bus_pkg.sv
package line_code_bus_pkg;

	// character layout on the 32-bit data bus, used by TX writes and RX reads
	// the byte sits in the low bits, the K flag right above it
	localparam int CHAR_BYTE_LSB = 0;
	localparam int CHAR_BYTE_W   = 8;
	localparam int CHAR_K_BIT    = 8;

	// bit positions in the status word
	// tx busy follows the pending flag of the transmit register
	localparam int STAT_TX_BUSY  = 0;
	// rx valid drops once the RX register has been read
	localparam int STAT_RX_VALID = 1;
	// the last three are sticky and cleared by writing a one to them
	localparam int STAT_OVERRUN  = 2;
	localparam int STAT_CODE_ERR = 3;
	localparam int STAT_DISP_ERR = 4;

endpackage

// File: design/enc_8b10b.sv
`timescale 1ns/1ps

module enc_8b10b import line_code_types_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       ena,
	input  logic       pend,
	input  logic [7:0] char_in,
	input  logic       k_in,
	output code_word_t dataout,
	output logic       take
);

	// character actually encoded this clock, {k, byte}
	logic [8:0] sel;
	// running disparity, 1 means positive
	logic       disp;
	logic       ai, bi, ci, di, ei, fi, gi, hi, ki;
	logic       aeqb, ceqd, l22, l40, l04, l13, l31;
	logic       a6, b6, c6, d6, e6, i6;
	logic       f4, g4, h4, j4;
	logic       pd1s6, nd1s6, ndos6, pdos6;
	logic       pd1s4, nd1s4, ndos4, pdos4;
	logic       alt7, compls6, compls4, disp6, disp_out;

	// with nothing pending the idle comma goes out instead
	assign sel = pend ? {k_in, char_in} : LC_IDLE_COMMA;
	assign ki  = sel[8];
	assign ai  = sel[0];
	assign bi  = sel[1];
	assign ci  = sel[2];
	assign di  = sel[3];
	assign ei  = sel[4];
	assign fi  = sel[5];
	assign gi  = sel[6];
	assign hi  = sel[7];

	// the pending character is consumed whenever the encoder runs
	assign take = ena & pend;

	// classify ABCD by how many ones it holds (l31 = three ones, one zero)
	assign aeqb = ai ~^ bi;
	assign ceqd = ci ~^ di;
	assign l22  = (ai & bi & !ci & !di) | (ci & di & !ai & !bi) | (!aeqb & !ceqd);
	assign l40  = ai & bi & ci & di;
	assign l04  = !ai & !bi & !ci & !di;
	assign l13  = (!aeqb & !ci & !di) | (!ceqd & !ai & !bi);
	assign l31  = (!aeqb & ci & di) | (!ceqd & ai & bi);

	// 5b/6b code before any complementing
	assign a6 = ai;
	assign b6 = (bi & !l40) | l04;
	assign c6 = l04 | ci | (ei & di & !ci & !bi & !ai);
	assign d6 = di & !(ai & bi & ci);
	assign e6 = (ei | l13) & !(ei & di & !ci & !bi & !ai);
	// i also covers D16..D18 and the K28 group
	assign i6 = (l22 & !ei) | (ei & !di & !ci & !(ai & bi)) | (ei & l40) |
		(ki & ei & di & ci & !bi & !ai) | (ei & !di & ci & !bi & !ai);

	// pd1s6 codes were built assuming positive disparity before them,
	// nd1s6 codes assuming negative; complement when the assumption is wrong
	assign pd1s6 = (ei & di & !ci & !bi & !ai) | (!ei & !l22 & !l31);
	assign nd1s6 = ki | (ei & !l22 & !l13) | (!ei & !di & ci & bi & ai);
	// every pd1s6 case flips the disparity, so do all nd1s6 cases but one
	assign ndos6 = pd1s6;
	assign pdos6 = ki | (ei & !l22 & !l13);

	assign compls6 = (pd1s6 & !disp) | (nd1s6 & disp);
	assign disp6   = disp ^ (ndos6 | pdos6);

	// x.7 would give a run of five after some 6b codes, those use the
	// alternate 0111/1000 form, and every Kx.7 does as well
	assign alt7 = fi & gi & hi & (ki | (disp ? (!ei & di & l31) : (ei & !di & l13)));

	// 3b/4b code before complementing
	assign f4 = fi & !alt7;
	assign g4 = gi | (!fi & !gi & !hi);
	assign h4 = hi;
	assign j4 = (!hi & (gi ^ fi)) | alt7;

	assign nd1s4 = fi & gi;
	// K codes complement x.1, x.2, x.5 and x.6 too, so commas keep their shape
	assign pd1s4 = (!fi & !gi) | (ki & (fi ^ gi));
	assign ndos4 = !fi & !gi;
	assign pdos4 = fi & gi & hi;

	assign compls4  = (pd1s4 & !disp6) | (nd1s4 & disp6);
	assign disp_out = disp6 ^ (ndos4 | pdos4);

	// symbol register, starts out at negative disparity with an all-zero word
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			disp    <= 1'b0;
			dataout <= '0;
		end else if (ena) begin
			disp         <= disp_out;
			dataout.word <= {a6 ^ compls6, b6 ^ compls6, c6 ^ compls6,
				d6 ^ compls6, e6 ^ compls6, i6 ^ compls6,
				f4 ^ compls4, g4 ^ compls4, h4 ^ compls4, j4 ^ compls4};
		end
	end

endmodule

// File: design/dec_8b10b.sv
`timescale 1ns/1ps

module dec_8b10b import line_code_types_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  code_word_t symbol,
	output logic [7:0] char_out,
	output logic       k_out,
	output logic       strobe,
	output logic       code_err,
	output logic       disp_err
);

	logic [5:0] six;
	logic [3:0] four;
	// fghj with the K28 positive form folded back onto the normal table
	logic [3:0] four_n;
	logic [4:0] d5;
	logic [2:0] d3;
	logic [2:0] six_ones;
	logic [2:0] four_ones;
	logic       six_ok, four_ok;
	logic       k28, k28_inv, a7, kx7;
	logic       run5, bad_a7, weight_bad, pair_bad;
	logic       six_pos, six_neg, four_pos, four_neg;
	// running disparity, 1 means positive
	logic       rd;
	logic       rd6, rd_next;
	logic       derr6, derr4;
	logic       err_code, err_disp;
	logic       k_dec;
	logic [7:0] char_dec;

	assign six  = symbol.blk.six;
	assign four = symbol.blk.four;

	assign k28     = (six == 6'b001111) | (six == 6'b110000);
	assign k28_inv = six == 6'b110000;
	assign four_n  = k28_inv ? ~four : four;

	// 6b lookup, both disparity forms of a character on the same line
	always_comb begin
		d5     = 5'd0;
		six_ok = 1'b1;
		case (six)
			6'b100111, 6'b011000: d5 = 5'd0;
			6'b011101, 6'b100010: d5 = 5'd1;
			6'b101101, 6'b010010: d5 = 5'd2;
			6'b110001:            d5 = 5'd3;
			6'b110101, 6'b001010: d5 = 5'd4;
			6'b101001:            d5 = 5'd5;
			6'b011001:            d5 = 5'd6;
			6'b111000, 6'b000111: d5 = 5'd7;
			6'b111001, 6'b000110: d5 = 5'd8;
			6'b100101:            d5 = 5'd9;
			6'b010101:            d5 = 5'd10;
			6'b110100:            d5 = 5'd11;
			6'b001101:            d5 = 5'd12;
			6'b101100:            d5 = 5'd13;
			6'b011100:            d5 = 5'd14;
			6'b010111, 6'b101000: d5 = 5'd15;
			6'b011011, 6'b100100: d5 = 5'd16;
			6'b100011:            d5 = 5'd17;
			6'b010011:            d5 = 5'd18;
			6'b110010:            d5 = 5'd19;
			6'b001011:            d5 = 5'd20;
			6'b101010:            d5 = 5'd21;
			6'b011010:            d5 = 5'd22;
			6'b111010, 6'b000101: d5 = 5'd23;
			6'b110011, 6'b001100: d5 = 5'd24;
			6'b100110:            d5 = 5'd25;
			6'b010110:            d5 = 5'd26;
			6'b110110, 6'b001001: d5 = 5'd27;
			6'b001110:            d5 = 5'd28;
			6'b101110, 6'b010001: d5 = 5'd29;
			6'b011110, 6'b100001: d5 = 5'd30;
			6'b101011, 6'b010100: d5 = 5'd31;
			6'b001111, 6'b110000: d5 = 5'd28;
			default:              six_ok = 1'b0;
		endcase
	end

	// 4b lookup, x.7 accepts both the primary and the alternate form
	always_comb begin
		d3      = 3'd0;
		four_ok = 1'b1;
		case (four_n)
			4'b1011, 4'b0100:                   d3 = 3'd0;
			4'b1001:                            d3 = 3'd1;
			4'b0101:                            d3 = 3'd2;
			4'b1100, 4'b0011:                   d3 = 3'd3;
			4'b1101, 4'b0010:                   d3 = 3'd4;
			4'b1010:                            d3 = 3'd5;
			4'b0110:                            d3 = 3'd6;
			4'b1110, 4'b0001, 4'b0111, 4'b1000: d3 = 3'd7;
			default:                            four_ok = 1'b0;
		endcase
	end

	// Kx.7 outside K28 is an alternate x.7 behind 23, 27, 29 or 30
	assign a7  = (four == 4'b0111) | (four == 4'b1000);
	assign kx7 = a7 & !k28 & (d5 inside {5'd23, 5'd27, 5'd29, 5'd30});

	// a legal 6b block holds 2, 3 or 4 ones, a 4b block 1, 2 or 3
	assign six_ones   = 3'($countones(six));
	assign four_ones  = 3'($countones(four));
	assign weight_bad = (six_ones < 3'd2) | (six_ones > 3'd4) |
		(four_ones < 3'd1) | (four_ones > 3'd3);

	// e,i,f,g,h all equal is a run of five across the sub-block boundary
	assign run5   = (&symbol.word[5:1]) | !(|symbol.word[5:1]);
	// the alternate x.7 only follows the 6b codes that need it
	assign bad_a7 = a7 & !k28 &
		!(d5 inside {5'd11, 5'd13, 5'd14, 5'd17, 5'd18, 5'd20, 5'd23, 5'd27, 5'd29, 5'd30});

	assign six_pos  = six_ones == 3'd4;
	assign six_neg  = six_ones == 3'd2;
	assign four_pos = four_ones == 3'd3;
	assign four_neg = four_ones == 3'd1;
	// two unbalanced sub-blocks of the same sign never occur
	assign pair_bad = (six_pos & four_pos) | (six_neg & four_neg);

	assign err_code = !six_ok | !four_ok | weight_bad | run5 | bad_a7 | pair_bad;

	// D7 and x.3 are balanced but still tied to one disparity
	assign derr6 = (six_pos & rd) | (six_neg & !rd) |
		((six == 6'b111000) & rd) | ((six == 6'b000111) & !rd);
	assign rd6   = six_pos ? 1'b1 : (six_neg ? 1'b0 : rd);
	assign derr4 = (four_pos & rd6) | (four_neg & !rd6) |
		((four == 4'b1100) & rd6) | ((four == 4'b0011) & !rd6);
	// an unbalanced block sets the disparity outright, which resyncs after errors
	assign rd_next  = four_pos ? 1'b1 : (four_neg ? 1'b0 : rd6);
	assign err_disp = derr6 | derr4;

	assign k_dec    = k28 | kx7;
	assign char_dec = {d3, d5};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd       <= 1'b0;
			strobe   <= 1'b0;
			code_err <= 1'b0;
			disp_err <= 1'b0;
		end else begin
			rd       <= rd_next;
			// idle and broken symbols never reach the holding register
			strobe   <= !err_code & ({k_dec, char_dec} != LC_IDLE_COMMA);
			code_err <= err_code;
			disp_err <= err_disp;
		end
	end

	always_ff @(posedge clk) begin
		char_out <= char_dec;
		k_out    <= k_dec;
	end

endmodule

// File: design/wb_link_regs.sv
`timescale 1ns/1ps
`include "line_code_config.svh"

module wb_link_regs import line_code_bus_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`LC_ADDR_W-1:0] adr,
	input  logic [31:0]           dat_w,
	input  logic                  we,
	input  logic                  cyc,
	input  logic                  stb,
	output logic [31:0]           dat_r,
	output logic                  ack,
	output logic [7:0]            tx_char,
	output logic                  tx_k,
	output logic                  tx_pend,
	input  logic                  take,
	input  logic [7:0]            rx_char,
	input  logic                  rx_k,
	input  logic                  rx_strobe,
	input  logic                  code_err,
	input  logic                  disp_err
);

	// set after an ack until the master drops stb
	logic        done;
	logic        acc;
	logic        hold_tx;
	logic        fire;
	logic        wr_tx, wr_stat, rd_rx;
	logic [31:0] rd_mux;
	logic [31:0] status;
	logic        rx_valid;
	logic        overrun, code_err_st, disp_err_st;
	logic [7:0]  hold_char;
	logic        hold_k;

	// a new access waits until the previous one has fully ended
	assign acc = cyc & stb & !ack & !done;
	// a TX write stalls while the encoder has not yet taken the last character
	assign hold_tx = we & (adr == `LC_REG_TX) & tx_pend;
	assign fire    = acc & !hold_tx;

	assign wr_tx   = fire & we & (adr == `LC_REG_TX);
	assign wr_stat = fire & we & (adr == `LC_REG_STATUS);
	assign rd_rx   = fire & !we & (adr == `LC_REG_RX);

	always_comb begin
		status                = '0;
		status[STAT_TX_BUSY]  = tx_pend;
		status[STAT_RX_VALID] = rx_valid;
		status[STAT_OVERRUN]  = overrun;
		status[STAT_CODE_ERR] = code_err_st;
		status[STAT_DISP_ERR] = disp_err_st;
	end

	// TX is write-only and reads back as zero, so does the unused offset
	always_comb begin
		rd_mux = '0;
		case (adr)
			`LC_REG_RX: begin
				rd_mux[CHAR_BYTE_LSB +: CHAR_BYTE_W] = hold_char;
				rd_mux[CHAR_K_BIT]                   = hold_k;
			end
			`LC_REG_STATUS: rd_mux = status;
			default:        rd_mux = '0;
		endcase
	end

	// bus handshake and pending flag
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ack     <= 1'b0;
			done    <= 1'b0;
			tx_pend <= 1'b0;
		end else begin
			ack <= fire;
			if (ack) begin
				done <= 1'b1;
			end else if (!(cyc & stb)) begin
				done <= 1'b0;
			end
			// a write cannot land while pending, so the two never collide
			if (wr_tx) begin
				tx_pend <= 1'b1;
			end else if (take) begin
				tx_pend <= 1'b0;
			end
		end
	end

	// receive side flags, sticky bits let a new error win over a clear
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rx_valid    <= 1'b0;
			overrun     <= 1'b0;
			code_err_st <= 1'b0;
			disp_err_st <= 1'b0;
		end else begin
			if (rx_strobe) begin
				rx_valid <= 1'b1;
			end else if (rd_rx) begin
				rx_valid <= 1'b0;
			end
			if (rx_strobe & rx_valid & !rd_rx) begin
				overrun <= 1'b1;
			end else if (wr_stat & dat_w[STAT_OVERRUN]) begin
				overrun <= 1'b0;
			end
			if (code_err) begin
				code_err_st <= 1'b1;
			end else if (wr_stat & dat_w[STAT_CODE_ERR]) begin
				code_err_st <= 1'b0;
			end
			if (disp_err) begin
				disp_err_st <= 1'b1;
			end else if (wr_stat & dat_w[STAT_DISP_ERR]) begin
				disp_err_st <= 1'b0;
			end
		end
	end

	// data registers, the newest received character always overwrites
	always_ff @(posedge clk) begin
		if (wr_tx) begin
			tx_char <= dat_w[CHAR_BYTE_LSB +: CHAR_BYTE_W];
			tx_k    <= dat_w[CHAR_K_BIT];
		end
		if (rx_strobe) begin
			hold_char <= rx_char;
			hold_k    <= rx_k;
		end
		if (fire & !we) begin
			dat_r <= rd_mux;
		end
	end

endmodule

// File: design/line_code_top.sv
`timescale 1ns/1ps
`include "line_code_config.svh"

module line_code_top import line_code_types_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`LC_ADDR_W-1:0] adr,
	input  logic [31:0]           dat_w,
	output logic [31:0]           dat_r,
	input  logic                  we,
	input  logic                  cyc,
	input  logic                  stb,
	output logic                  ack,
	output code_word_t            tx_symbol,
	input  code_word_t            rx_symbol
);

	// transmit register to encoder
	logic [7:0] tx_char;
	logic       tx_k;
	logic       tx_pend;
	logic       tx_take;
	// decoder to receive holding register and status
	logic [7:0] rx_char;
	logic       rx_k;
	logic       rx_strobe;
	logic       code_err;
	logic       disp_err;

	wb_link_regs u_regs (
		.clk       (clk),
		.rst       (rst),
		.adr       (adr),
		.dat_w     (dat_w),
		.we        (we),
		.cyc       (cyc),
		.stb       (stb),
		.dat_r     (dat_r),
		.ack       (ack),
		.tx_char   (tx_char),
		.tx_k      (tx_k),
		.tx_pend   (tx_pend),
		.take      (tx_take),
		.rx_char   (rx_char),
		.rx_k      (rx_k),
		.rx_strobe (rx_strobe),
		.code_err  (code_err),
		.disp_err  (disp_err)
	);

	// the line runs continuously, so the encoder is always enabled
	enc_8b10b u_enc (
		.clk     (clk),
		.rst     (rst),
		.ena     (1'b1),
		.pend    (tx_pend),
		.char_in (tx_char),
		.k_in    (tx_k),
		.dataout (tx_symbol),
		.take    (tx_take)
	);

	dec_8b10b u_dec (
		.clk      (clk),
		.rst      (rst),
		.symbol   (rx_symbol),
		.char_out (rx_char),
		.k_out    (rx_k),
		.strobe   (rx_strobe),
		.code_err (code_err),
		.disp_err (disp_err)
	);

endmodule

// File: tests/line_code_asserts.sv
`timescale 1ns/1ps
`include "line_code_config.svh"

module line_code_asserts (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic tx_pend
);

	// one flag per property, set once the property has failed
	logic ack_twice_bad = 1'b0;
	logic ack_rise_bad  = 1'b0;
	logic pend_bad      = 1'b0;
	logic wait_bad      = 1'b0;
	// the testbench polls this one
	logic failed;
	// clocks the current access has been waiting for ack
	int unsigned wait_cnt;

	assign failed = ack_twice_bad | ack_rise_bad | pend_bad | wait_bad;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wait_cnt <= 0;
		end else if (cyc && stb && !ack) begin
			wait_cnt <= wait_cnt + 1;
		end else begin
			wait_cnt <= 0;
		end
	end

	// an access is acknowledged for exactly one clock
	ack_single: assert property (@(posedge clk) disable iff (!rst) ack |=> !ack)
		else begin
			$error("ack stayed high for two cycles in a row");
			ack_twice_bad = 1'b1;
		end

	// ack only answers a cycle the master is actually running
	ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
		$rose(ack) |-> (cyc && stb))
		else begin
			$error("ack rose without cyc and stb");
			ack_rise_bad = 1'b1;
		end

	// the encoder takes a pending character within two clocks
	pend_clears: assert property (@(posedge clk) disable iff (!rst)
		!(tx_pend && $past(tx_pend) && $past(tx_pend, 2)))
		else begin
			$error("tx_pend stayed set for three cycles");
			pend_bad = 1'b1;
		end

	// no access waits longer than the testbench timeout
	ack_bounded: assert property (@(posedge clk) disable iff (!rst)
		wait_cnt < `LC_TIMEOUT)
		else begin
			$error("an access waited too long for ack");
			wait_bad = 1'b1;
		end

endmodule

bind line_code_top line_code_asserts u_asserts (
	.clk     (clk),
	.rst     (rst),
	.cyc     (cyc),
	.stb     (stb),
	.ack     (ack),
	.tx_pend (tx_pend)
);

// File: tests/line_code_tb.sv
`timescale 1ns/1ps
`include "line_code_config.svh"

module line_code_tb
	import line_code_types_pkg::*, line_code_bus_pkg::*;
();

	// K28.5 for negative and for positive running disparity
	localparam logic [9:0] COMMA_NEG = 10'b0011111010;
	localparam logic [9:0] COMMA_POS = 10'b1100000101;
	localparam int TBL_N  = 20;
	localparam int RAND_N = 16;

	// one row per character, {k, byte, expected k, expected byte}
	localparam logic [17:0] TBL [TBL_N] = '{
		{1'b0, 8'h00, 1'b0, 8'h00},  // D0.0
		{1'b0, 8'hB5, 1'b0, 8'hB5},  // D21.5
		{1'b0, 8'hFF, 1'b0, 8'hFF},  // D31.7
		{1'b0, 8'hEB, 1'b0, 8'hEB},  // D11.7, alternate form
		{1'b0, 8'hF1, 1'b0, 8'hF1},  // D17.7, alternate form
		{1'b0, 8'hF7, 1'b0, 8'hF7},  // D23.7
		{1'b1, 8'h1C, 1'b1, 8'h1C},  // K28.0
		{1'b1, 8'hFC, 1'b1, 8'hFC},  // K28.7
		{1'b1, 8'hF7, 1'b1, 8'hF7},  // K23.7
		{1'b1, 8'hFB, 1'b1, 8'hFB},  // K27.7
		{1'b1, 8'hFD, 1'b1, 8'hFD},  // K29.7
		{1'b1, 8'hFE, 1'b1, 8'hFE},  // K30.7
		{1'b0, 8'h4A, 1'b0, 8'h4A},  // D10.2
		{1'b0, 8'h63, 1'b0, 8'h63},  // D3.3
		{1'b0, 8'h27, 1'b0, 8'h27},  // D7.1
		{1'b0, 8'hEE, 1'b0, 8'hEE},  // D14.7
		{1'b0, 8'hF4, 1'b0, 8'hF4},  // D20.7
		{1'b1, 8'h3C, 1'b1, 8'h3C},  // K28.1
		{1'b0, 8'h90, 1'b0, 8'h90},  // D16.4
		{1'b0, 8'hDB, 1'b0, 8'hDB}   // D27.6
	};

	logic                  clk;
	logic                  rst;
	logic [`LC_ADDR_W-1:0] adr;
	logic [31:0]           dat_w;
	logic [31:0]           dat_r;
	logic                  we;
	logic                  cyc;
	logic                  stb;
	logic                  ack;
	code_word_t            tx_symbol;
	code_word_t            rx_symbol;
	// rx_symbol follows tx_symbol in loopback, else it carries inj_sym
	logic                  loop_en;
	code_word_t            inj_sym;
	logic                  mon_on;
	// set while no character is on its way, so only commas may go out
	logic                  expect_idle;
	// running sum of (ones - 5) over every symbol since reset
	int                    bal;
	int                    seed;

	assign rx_symbol = loop_en ? tx_symbol : inj_sym;

	line_code_top dut (
		.clk       (clk),
		.rst       (rst),
		.adr       (adr),
		.dat_w     (dat_w),
		.dat_r     (dat_r),
		.we        (we),
		.cyc       (cyc),
		.stb       (stb),
		.ack       (ack),
		.tx_symbol (tx_symbol),
		.rx_symbol (rx_symbol)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_char(input string name, input logic [7:0] got_byte, input logic got_k,
		input logic [7:0] exp_byte, input logic exp_k);
		if (got_byte !== exp_byte || got_k !== exp_k) begin
			abort_run($sformatf("[FAIL] %s: got byte %h k %h, expected byte %h k %h",
				name, got_byte, got_k, exp_byte, exp_k));
		end
	endtask

	task automatic check_status(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_symbol(input string name, input code_word_t got, input code_word_t exp);
		if (got.word !== exp.word) begin
			abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got.word, exp.word));
		end
	endtask

	// status word as the rules expect it, tx busy is always clear when read here
	function automatic logic [31:0] make_status(input logic valid, input logic ovr,
		input logic cerr, input logic derr);
		logic [31:0] s;
		s                = '0;
		s[STAT_RX_VALID] = valid;
		s[STAT_OVERRUN]  = ovr;
		s[STAT_CODE_ERR] = cerr;
		s[STAT_DISP_ERR] = derr;
		return s;
	endfunction

	// one classic cycle, held until ack is seen and then released
	task automatic bus_access(input logic [`LC_ADDR_W-1:0] a, input logic wr,
		input logic [31:0] d, output logic [31:0] q);
		int n;
		@(posedge clk);
		#5;
		if (wr && a == `LC_REG_TX) begin
			expect_idle = 1'b0;
		end
		adr   = a;
		we    = wr;
		dat_w = d;
		cyc   = 1'b1;
		stb   = 1'b1;
		n     = 0;
		@(negedge clk);
		while (!ack && n < `LC_TIMEOUT) begin
			n++;
			@(negedge clk);
		end
		q = dat_r;
		if (!ack) begin
			abort_run("timed out waiting for ack from the Wishbone slave");
		end else begin
			@(posedge clk);
			#5;
			cyc = 1'b0;
			stb = 1'b0;
			we  = 1'b0;
		end
	endtask

	task automatic bus_write(input logic [`LC_ADDR_W-1:0] a, input logic [31:0] d);
		logic [31:0] unused_q;
		bus_access(a, 1'b1, d, unused_q);
	endtask

	task automatic bus_read(input logic [`LC_ADDR_W-1:0] a, output logic [31:0] q);
		bus_access(a, 1'b0, 32'h0, q);
	endtask

	// poll STATUS until the given bit is set
	task automatic wait_status_bit(input int idx, input string what);
		logic [31:0] st;
		int n;
		n = 0;
		bus_read(`LC_REG_STATUS, st);
		while (!st[idx] && n < `LC_TIMEOUT) begin
			n++;
			bus_read(`LC_REG_STATUS, st);
		end
		if (!st[idx]) begin
			abort_run({"timed out waiting for ", what});
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#5;
	endtask

	// replace the line for count clocks, then go back to loopback
	task automatic inject_symbols(input logic [9:0] sym, input int count);
		@(posedge clk);
		#5;
		inj_sym.word = sym;
		loop_en      = 1'b0;
		repeat (count) @(posedge clk);
		#5;
		loop_en = 1'b1;
	endtask

	// send one character through the line and read it back from RX
	task automatic loop_char(input logic [7:0] b, input logic k, input logic [7:0] eb,
		input logic ek);
		logic [31:0] d;
		logic [31:0] q;
		d                                = '0;
		d[CHAR_BYTE_LSB +: CHAR_BYTE_W] = b;
		d[CHAR_K_BIT]                    = k;
		bus_write(`LC_REG_TX, d);
		wait_status_bit(STAT_RX_VALID, "a received character");
		bus_read(`LC_REG_RX, q);
		check_char("rx", q[CHAR_BYTE_LSB +: CHAR_BYTE_W], q[CHAR_K_BIT], eb, ek);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after rx read", q, make_status(1'b0, 1'b0, 1'b0, 1'b0));
		expect_idle = 1'b1;
	endtask

	// weight and balance of every symbol, and the comma shape while idle
	always @(negedge clk) begin : line_monitor
		int ones;
		code_word_t exp_sym;
		if (dut.u_asserts.failed) begin
			abort_run("an assertion on the bus handshake or the transmit flag failed");
		end else if (mon_on) begin
			ones = $countones(tx_symbol.word);
			if (ones < 4 || ones > 6) begin
				abort_run($sformatf("[FAIL] tx_symbol: %h is not a balanced code", tx_symbol.word));
			end else begin
				if (expect_idle) begin
					// bal is 0 while the line disparity is negative
					exp_sym.word = (bal == 0) ? COMMA_NEG : COMMA_POS;
					check_symbol("tx_symbol", tx_symbol, exp_sym);
				end
				bal = bal + ones - 5;
				if (bal < -1 || bal > 1) begin
					abort_run($sformatf("[FAIL] tx_symbol: %h drives the running sum to %h",
						tx_symbol.word, bal));
				end
			end
		end
	end

	initial begin : main
		logic [31:0] q;
		logic [31:0] rnd;
		logic [17:0] row;
		int i;
		rst          = 1'b0;
		adr          = '0;
		dat_w        = '0;
		we           = 1'b0;
		cyc          = 1'b0;
		stb          = 1'b0;
		loop_en      = 1'b1;
		inj_sym.word = '0;
		mon_on       = 1'b0;
		expect_idle  = 1'b0;
		bal          = 0;
		seed         = 32'h2c03a763;
		repeat (8) @(posedge clk);
		#5;
		rst = 1'b1;
		// the first encoded symbol shows up one clock after reset ends
		@(posedge clk);
		#5;
		mon_on      = 1'b1;
		expect_idle = 1'b1;

		// commas alone never make RX valid, but the all-zero word the encoder
		// holds in reset is decoded once and leaves a code error behind
		idle_cycles(20);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after idle", q, make_status(1'b0, 1'b0, 1'b1, 1'b0));
		bus_write(`LC_REG_STATUS, 32'h1 << STAT_CODE_ERR);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after reset clear", q, make_status(1'b0, 1'b0, 1'b0, 1'b0));

		for (i = 0; i < TBL_N; i++) begin
			row = TBL[i];
			loop_char(row[16:9], row[17], row[7:0], row[8]);
		end
		for (i = 0; i < RAND_N; i++) begin
			rnd = $random(seed);
			loop_char(rnd[7:0], 1'b0, rnd[7:0], 1'b0);
		end

		// the decoder misses one idle comma, so the next one also breaks disparity
		inject_symbols(10'b0000000000, 1);
		idle_cycles(4);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after code error", q, make_status(1'b0, 1'b0, 1'b1, 1'b1));
		bus_write(`LC_REG_STATUS, 32'h1 << STAT_CODE_ERR);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after code clear", q, make_status(1'b0, 1'b0, 1'b0, 1'b1));
		bus_write(`LC_REG_STATUS, 32'h1 << STAT_DISP_ERR);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after disparity clear", q, make_status(1'b0, 1'b0, 1'b0, 1'b0));

		// the same positive comma twice cannot be right at both positions
		inject_symbols(COMMA_POS, 2);
		idle_cycles(4);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after disparity error", q, make_status(1'b0, 1'b0, 1'b0, 1'b1));
		bus_write(`LC_REG_STATUS, 32'h1 << STAT_DISP_ERR);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after disparity clear", q, make_status(1'b0, 1'b0, 1'b0, 1'b0));

		// a second character lands on an unread one
		bus_write(`LC_REG_TX, 32'h05A);
		wait_status_bit(STAT_RX_VALID, "the first overrun character");
		bus_write(`LC_REG_TX, 32'h0A5);
		wait_status_bit(STAT_OVERRUN, "the overrun flag");
		bus_read(`LC_REG_STATUS, q);
		check_status("status after overrun", q, make_status(1'b1, 1'b1, 1'b0, 1'b0));
		bus_read(`LC_REG_RX, q);
		check_char("rx after overrun", q[CHAR_BYTE_LSB +: CHAR_BYTE_W], q[CHAR_K_BIT],
			8'hA5, 1'b0);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after overrun read", q, make_status(1'b0, 1'b1, 1'b0, 1'b0));
		bus_write(`LC_REG_STATUS, 32'h1 << STAT_OVERRUN);
		bus_read(`LC_REG_STATUS, q);
		check_status("status after overrun clear", q, make_status(1'b0, 1'b0, 1'b0, 1'b0));
		expect_idle = 1'b1;
		idle_cycles(10);

		$display("all tests passed");
		$finish;
	end

endmodule

// File: line_code.f
+incdir+include
design/line_code_types_pkg.sv
design/line_code_bus_pkg.sv
design/enc_8b10b.sv
design/dec_8b10b.sv
design/wb_link_regs.sv
design/line_code_top.sv
tests/line_code_asserts.sv
tests/line_code_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the line code testbench with Verilator and run it
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module line_code_tb \
	-Mdir obj_dir \
	-f line_code.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

# assertion errors keep the run going so the testbench can stop it
./obj_dir/Vline_code_tb +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
fi
exit "$status"
